//--- common/scaler_pkg.sv
// Assumes an 8-bit greyscale image in a 64 KB memory whose upper half holds the output
package scaler_pkg;

    // ======================================================================
    // Widths
    // ======================================================================
    localparam int pixel_width = 8;
    localparam int addr_width  = 16;
    localparam int coord_width = 16;
    localparam int frac_width  = 8;
    localparam int seg_width   = 7;

    // Bytes in the pixel memory
    localparam int mem_depth = 1 << addr_width;

    // ======================================================================
    // Types
    // ======================================================================
    // One greyscale sample
    typedef logic [pixel_width-1:0] pixel_t;

    // Byte address into pixel memory
    typedef logic [addr_width-1:0] addr_t;

    // Pixel coordinate, input or output image
    typedef logic [coord_width-1:0] coord_t;

    // Interpolation weight in 1/256 units
    typedef logic [frac_width-1:0] frac_t;

    // Scale factor, also in 1/256 units
    typedef logic [frac_width-1:0] scale_t;

    // Active-low segments, bit 6 is g and bit 0 is a
    typedef logic [seg_width-1:0] seg_t;

    // Output image starts halfway up the memory
    localparam addr_t output_base = addr_t'(mem_depth / 2);

endpackage

//--- common/fetch_if.sv
// Only one fetch may be outstanding and the pixels hold from done until the next req
`timescale 1ns/1ns

interface fetch_if;

    // Request side, req is a single-cycle strobe
    logic               req;
    scaler_pkg::coord_t x_int;
    scaler_pkg::coord_t y_int;

    // Response side
    logic               done;
    scaler_pkg::pixel_t p00;
    scaler_pkg::pixel_t p01;
    scaler_pkg::pixel_t p10;
    scaler_pkg::pixel_t p11;

    // Scan controller end
    modport requester (
        output req, x_int, y_int,
        input  done, p00, p01, p10, p11
    );

    // Neighbour fetcher end
    modport responder (
        input  req, x_int, y_int,
        output done, p00, p01, p10, p11
    );

endinterface

//--- hdl/key_input.sv
// Keys are active low and not debounced, so a bouncing key can give several steps
`timescale 1ns/1ns

module key_input (
    input  logic              clk,
    input  logic              reset_n,
    input  logic [2:0]        key_n,
    output logic              clear,
    output scaler_pkg::addr_t manual_addr
);

    // Two sample stages, released keys read as ones
    logic [2:0] key_s;
    logic [2:0] key_q;
    // Registered falling-edge pulses
    logic [2:0] key_fall;

    // ======================================================================
    // Edge detection
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            key_s    <= 3'b111;
            key_q    <= 3'b111;
            key_fall <= 3'b000;
        end else begin
            key_s    <= key_n;
            key_q    <= key_s;
            // High to low between the two samples
            key_fall <= key_q & ~key_s;
        end
    end

    // ======================================================================
    // Manual view address
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            manual_addr <= '0;
        end else if (key_fall[0]) begin
            // Step up, wraps at the top
            manual_addr <= manual_addr + 1'b1;
        end else if (key_fall[1] && manual_addr != '0) begin
            // Step down, floor at zero
            manual_addr <= manual_addr - 1'b1;
        end
    end

    // Key 2 aborts the engine
    assign clear = key_fall[2];

endmodule

//--- hdl/pixel_ram.sv
// Read during write to one address returns the old byte and the contents start undefined
`timescale 1ns/1ns

module pixel_ram (
    input  logic               clk,
    input  logic               wr_en,
    input  scaler_pkg::addr_t  wr_addr,
    input  scaler_pkg::pixel_t wr_data,
    input  scaler_pkg::addr_t  rd_addr,
    output scaler_pkg::pixel_t rd_data
);

    // Full 64 KB byte array
    scaler_pkg::pixel_t mem [0:scaler_pkg::mem_depth-1];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, one cycle of latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- hdl/seg_display.sv
// The data input must come from a memory with one cycle of read latency
`timescale 1ns/1ns

module seg_display (
    input  logic               clk,
    input  logic               reset_n,
    input  scaler_pkg::addr_t  view_addr,
    input  scaler_pkg::pixel_t view_data,
    output scaler_pkg::seg_t   hex0,
    output scaler_pkg::seg_t   hex1,
    output scaler_pkg::seg_t   hex2,
    output scaler_pkg::seg_t   hex3,
    output scaler_pkg::seg_t   hex4,
    output scaler_pkg::seg_t   hex5
);

    // Address delayed to line up with the memory data
    scaler_pkg::addr_t  addr_d;
    // Display register
    scaler_pkg::addr_t  addr_q;
    scaler_pkg::pixel_t data_q;

    // Hex digit to segments, letters b and d in lower case
    function automatic scaler_pkg::seg_t hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'ha:    return 7'b0001000;
            4'hb:    return 7'b0000011;
            4'hc:    return 7'b1000110;
            4'hd:    return 7'b0100001;
            4'he:    return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            addr_d <= '0;
            addr_q <= '0;
            data_q <= '0;
        end else begin
            addr_d <= view_addr;
            addr_q <= addr_d;
            data_q <= view_data;
        end
    end

    // Data on digits 1..0
    assign hex0 = hex_to_seg(data_q[3:0]);
    assign hex1 = hex_to_seg(data_q[7:4]);
    // Address on digits 5..2
    assign hex2 = hex_to_seg(addr_q[3:0]);
    assign hex3 = hex_to_seg(addr_q[7:4]);
    assign hex4 = hex_to_seg(addr_q[11:8]);
    assign hex5 = hex_to_seg(addr_q[15:12]);

endmodule

//--- scaler/scan_control.sv
// Scale and side length are latched at the start of a run and img_dim must be at most 128
`timescale 1ns/1ns

module scan_control #(
    parameter int img_dim = 16
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               clear,
    input  logic               run,
    input  scaler_pkg::scale_t scale,
    input  logic               dp_done,
    input  scaler_pkg::pixel_t pixel,
    output logic               dp_start,
    output scaler_pkg::frac_t  frac_x,
    output scaler_pkg::frac_t  frac_y,
    output logic               wr_en,
    output scaler_pkg::addr_t  wr_addr,
    output scaler_pkg::pixel_t wr_data,
    output logic               busy,
    output logic               ready,
    fetch_if.requester         fetch
);

    typedef enum logic [2:0] {
        st_idle,
        st_req,
        st_wait_fetch,
        st_start,
        st_wait_dp,
        st_ready
    } state_t;

    state_t             state;
    // Output side length, live and latched
    scaler_pkg::coord_t out_dim;
    scaler_pkg::coord_t out_dim_q;
    // Q8.8 inverse scale, 65536 for a factor of 1
    logic [16:0]        inv_scale;
    logic [16:0]        inv_q;
    // Current output coordinate
    scaler_pkg::coord_t ox;
    scaler_pkg::coord_t oy;
    // Running write address, rows are packed at out_dim stride
    scaler_pkg::addr_t  wr_ptr;
    // Source coordinates in Q8.8
    logic [32:0]        src_x;
    logic [32:0]        src_y;
    logic               last_col;
    logic               last_pixel;

    // ======================================================================
    // Geometry
    // ======================================================================
    assign out_dim   = scaler_pkg::coord_t'((img_dim * scale) >> 8);
    // Zero factor falls back to unity
    assign inv_scale = (scale != '0) ? 17'd65536 / scale : 17'd256;

    assign src_x = ox * inv_q;
    assign src_y = oy * inv_q;

    assign last_col   = (ox == out_dim_q - 1'b1);
    assign last_pixel = last_col && (oy == out_dim_q - 1'b1);

    // ======================================================================
    // Scan FSM
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= st_idle;
            out_dim_q <= '0;
            inv_q     <= '0;
            ox        <= '0;
            oy        <= '0;
            wr_ptr    <= '0;
        end else if (clear) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (run) begin
                        out_dim_q <= out_dim;
                        inv_q     <= inv_scale;
                        ox        <= '0;
                        oy        <= '0;
                        wr_ptr    <= scaler_pkg::output_base;
                        // Empty output needs no scan
                        state     <= (out_dim == '0) ? st_ready : st_req;
                    end
                end
                st_req: state <= st_wait_fetch;
                st_wait_fetch: begin
                    if (fetch.done) begin
                        state <= st_start;
                    end
                end
                st_start: state <= st_wait_dp;
                st_wait_dp: begin
                    if (dp_done) begin
                        wr_ptr <= wr_ptr + 1'b1;
                        if (last_pixel) begin
                            state <= st_ready;
                        end else begin
                            state <= st_req;
                            // Row by row
                            if (last_col) begin
                                ox <= '0;
                                oy <= oy + 1'b1;
                            end else begin
                                ox <= ox + 1'b1;
                            end
                        end
                    end
                end
                st_ready: begin
                    // Hold until run is dropped
                    if (!run) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Fetch request with integer part of the source coordinate
    assign fetch.req   = (state == st_req);
    assign fetch.x_int = src_x[23:8];
    assign fetch.y_int = src_y[23:8];

    // Weights stay put until the write
    assign frac_x   = src_x[7:0];
    assign frac_y   = src_y[7:0];
    assign dp_start = (state == st_start);

    // Write lands on the dp_done edge
    assign wr_en   = (state == st_wait_dp) && dp_done;
    assign wr_addr = wr_ptr;
    assign wr_data = pixel;

    assign busy  = (state != st_idle) && (state != st_ready);
    assign ready = (state == st_ready);

endmodule

//--- scaler/neighbour_fetch.sv
// The input image sits at address 0 with img_dim at most 128 and indices past the edge clamp
`timescale 1ns/1ns

module neighbour_fetch #(
    parameter int img_dim = 16
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               clear,
    input  scaler_pkg::pixel_t rd_data,
    output scaler_pkg::addr_t  rd_addr,
    fetch_if.responder         fetch
);

    // Last valid row or column
    localparam scaler_pkg::coord_t last_idx = scaler_pkg::coord_t'(img_dim - 1);

    logic               active;
    // Read slot, data of slot k returns in slot k+1
    logic [2:0]         step;
    // Clamped neighbourhood corners
    scaler_pkg::coord_t x0;
    scaler_pkg::coord_t x1;
    scaler_pkg::coord_t y0;
    scaler_pkg::coord_t y1;
    scaler_pkg::coord_t row;
    scaler_pkg::coord_t col;
    logic               accept;

    function automatic scaler_pkg::coord_t clamp(input scaler_pkg::coord_t v);
        return (v > last_idx) ? last_idx : v;
    endfunction

    assign accept = !active && fetch.req;

    // ======================================================================
    // Sequencer
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active     <= 1'b0;
            step       <= '0;
            fetch.done <= 1'b0;
        end else if (clear) begin
            active     <= 1'b0;
            step       <= '0;
            fetch.done <= 1'b0;
        end else begin
            fetch.done <= 1'b0;
            if (accept) begin
                active <= 1'b1;
                step   <= '0;
            end else if (active) begin
                step <= step + 1'b1;
                // p11 arrives in slot 4
                if (step == 3'd4) begin
                    active     <= 1'b0;
                    fetch.done <= 1'b1;
                end
            end
        end
    end

    // Coordinates and pixels
    always_ff @(posedge clk) begin
        if (accept) begin
            x0 <= clamp(fetch.x_int);
            x1 <= clamp(fetch.x_int + 1'b1);
            y0 <= clamp(fetch.y_int);
            y1 <= clamp(fetch.y_int + 1'b1);
        end
        if (active) begin
            case (step)
                3'd1:    fetch.p00 <= rd_data;
                3'd2:    fetch.p01 <= rd_data;
                3'd3:    fetch.p10 <= rd_data;
                3'd4:    fetch.p11 <= rd_data;
                default: ;
            endcase
        end
    end

    // Slot order 00, 01, 10, 11
    assign row     = step[1] ? y1 : y0;
    assign col     = step[0] ? x1 : x0;
    assign rd_addr = scaler_pkg::addr_t'(row * img_dim + col);

endmodule

//--- scaler/bilinear_datapath.sv
// Result is truncated and not rounded, with a fixed latency of two cycles
`timescale 1ns/1ns

module bilinear_datapath (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               start,
    input  scaler_pkg::pixel_t p00,
    input  scaler_pkg::pixel_t p01,
    input  scaler_pkg::pixel_t p10,
    input  scaler_pkg::pixel_t p11,
    input  scaler_pkg::frac_t  frac_x,
    input  scaler_pkg::frac_t  frac_y,
    output scaler_pkg::pixel_t pixel,
    output logic               done
);

    // Complementary weights, 256 when the fraction is 0
    logic [8:0]        wx0;
    logic [8:0]        wy0;
    // Row blends, at most 255 * 256
    logic [16:0]       top_sum;
    logic [16:0]       bot_sum;
    logic [16:0]       top_q;
    logic [16:0]       bot_q;
    scaler_pkg::frac_t fy_q;
    logic              s1_valid;
    // Vertical blend in 1/65536 units
    logic [24:0]       vert_sum;

    // ======================================================================
    // Stage 1, horizontal
    // ======================================================================
    assign wx0     = 9'd256 - frac_x;
    assign top_sum = p00 * wx0 + p01 * frac_x;
    assign bot_sum = p10 * wx0 + p11 * frac_x;

    // ======================================================================
    // Stage 2, vertical
    // ======================================================================
    assign wy0      = 9'd256 - fy_q;
    assign vert_sum = top_q * wy0 + bot_q * fy_q;

    // Valid pipe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= start;
            done     <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            top_q <= top_sum;
            bot_q <= bot_sum;
            fy_q  <= frac_y;
        end
        if (s1_valid) begin
            pixel <= vert_sum[23:16];
        end
    end

endmodule

//--- hdl/scaler_top.sv
// The engine owns both memory ports while busy and load writes in that time are dropped
`timescale 1ns/1ns

module scaler_top #(
    parameter int img_dim = 16
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic [2:0]         key_n,
    input  logic               view_manual,
    input  logic               run,
    input  scaler_pkg::scale_t scale,
    input  scaler_pkg::addr_t  load_addr,
    input  scaler_pkg::pixel_t load_data,
    input  logic               load_write,
    output scaler_pkg::seg_t   hex0,
    output scaler_pkg::seg_t   hex1,
    output scaler_pkg::seg_t   hex2,
    output scaler_pkg::seg_t   hex3,
    output scaler_pkg::seg_t   hex4,
    output scaler_pkg::seg_t   hex5,
    output logic               busy,
    output logic               ready
);

    logic               clear;
    scaler_pkg::addr_t  manual_addr;
    scaler_pkg::addr_t  view_addr;

    // Memory ports after the multiplexer
    logic               ram_wr_en;
    scaler_pkg::addr_t  ram_wr_addr;
    scaler_pkg::pixel_t ram_wr_data;
    scaler_pkg::addr_t  ram_rd_addr;
    scaler_pkg::pixel_t ram_rd_data;

    // Engine side
    logic               eng_wr_en;
    scaler_pkg::addr_t  eng_wr_addr;
    scaler_pkg::pixel_t eng_wr_data;
    scaler_pkg::addr_t  fetch_rd_addr;
    logic               dp_start;
    logic               dp_done;
    scaler_pkg::frac_t  frac_x;
    scaler_pkg::frac_t  frac_y;
    scaler_pkg::pixel_t dp_pixel;

    fetch_if fetch_bus ();

    // ======================================================================
    // Memory port multiplexer
    // ======================================================================
    assign view_addr = view_manual ? manual_addr : load_addr;

    always_comb begin
        if (busy) begin
            ram_wr_en   = eng_wr_en;
            ram_wr_addr = eng_wr_addr;
            ram_wr_data = eng_wr_data;
            ram_rd_addr = fetch_rd_addr;
        end else begin
            ram_wr_en   = load_write;
            ram_wr_addr = load_addr;
            ram_wr_data = load_data;
            ram_rd_addr = view_addr;
        end
    end

    // ======================================================================
    // Instances
    // ======================================================================
    key_input u_keys (
        .clk         (clk),
        .reset_n     (reset_n),
        .key_n       (key_n),
        .clear       (clear),
        .manual_addr (manual_addr)
    );

    pixel_ram u_ram (
        .clk     (clk),
        .wr_en   (ram_wr_en),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

    scan_control #(
        .img_dim (img_dim)
    ) u_ctrl (
        .clk      (clk),
        .reset_n  (reset_n),
        .clear    (clear),
        .run      (run),
        .scale    (scale),
        .dp_done  (dp_done),
        .pixel    (dp_pixel),
        .dp_start (dp_start),
        .frac_x   (frac_x),
        .frac_y   (frac_y),
        .wr_en    (eng_wr_en),
        .wr_addr  (eng_wr_addr),
        .wr_data  (eng_wr_data),
        .busy     (busy),
        .ready    (ready),
        .fetch    (fetch_bus.requester)
    );

    neighbour_fetch #(
        .img_dim (img_dim)
    ) u_fetch (
        .clk     (clk),
        .reset_n (reset_n),
        .clear   (clear),
        .rd_data (ram_rd_data),
        .rd_addr (fetch_rd_addr),
        .fetch   (fetch_bus.responder)
    );

    bilinear_datapath u_dp (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (dp_start),
        .p00     (fetch_bus.p00),
        .p01     (fetch_bus.p01),
        .p10     (fetch_bus.p10),
        .p11     (fetch_bus.p11),
        .frac_x  (frac_x),
        .frac_y  (frac_y),
        .pixel   (dp_pixel),
        .done    (dp_done)
    );

    // Shows the selected view address and the byte read there
    seg_display u_disp (
        .clk       (clk),
        .reset_n   (reset_n),
        .view_addr (view_addr),
        .view_data (ram_rd_data),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3),
        .hex4      (hex4),
        .hex5      (hex5)
    );

endmodule

//--- verification/scaler_properties.sv
// Checks only the engine strobes and is bound into every scan_control instance
`timescale 1ns/1ns

module scaler_properties (
    input logic clk,
    input logic reset_n,
    input logic busy,
    input logic ready,
    input logic dp_start,
    input logic dp_done,
    input logic wr_en
);

    // Running and finished never overlap
    busy_ready_exclusive: assert property (
        @(posedge clk) disable iff (!reset_n) !(busy && ready)
    ) else $error("busy and ready are high together");

    // Fixed datapath latency
    start_then_done: assert property (
        @(posedge clk) disable iff (!reset_n) dp_start |-> ##2 dp_done
    ) else $error("dp_done missing two cycles after dp_start");

    done_after_start: assert property (
        @(posedge clk) disable iff (!reset_n) dp_done |-> $past(dp_start, 2)
    ) else $error("dp_done without dp_start two cycles before");

    // Output writes only inside a run
    write_only_busy: assert property (
        @(posedge clk) disable iff (!reset_n) wr_en |-> busy
    ) else $error("wr_en high while not busy");

endmodule

bind scan_control scaler_properties props0 (
    .clk      (clk),
    .reset_n  (reset_n),
    .busy     (busy),
    .ready    (ready),
    .dp_start (dp_start),
    .dp_done  (dp_done),
    .wr_en    (wr_en)
);

//--- verification/scaler_tb.sv
// Assumes a 16 by 16 input image at address 0 and reads all results back through the display
`timescale 1ns/1ns

module scaler_tb;

    localparam int img_dim     = 16;
    localparam int run_limit   = 20000;
    localparam int short_limit = 40;
    // Selectors for wait_flag
    localparam int sel_busy    = 0;
    localparam int sel_ready   = 1;

    logic               clk;
    logic               reset_n;
    logic [2:0]         key_n;
    logic               view_manual;
    logic               run;
    scaler_pkg::scale_t scale;
    scaler_pkg::addr_t  load_addr;
    scaler_pkg::pixel_t load_data;
    logic               load_write;
    scaler_pkg::seg_t   hex0;
    scaler_pkg::seg_t   hex1;
    scaler_pkg::seg_t   hex2;
    scaler_pkg::seg_t   hex3;
    scaler_pkg::seg_t   hex4;
    scaler_pkg::seg_t   hex5;
    logic               busy;
    logic               ready;

    integer             seed;
    // Expected memory contents, input image and output image
    scaler_pkg::pixel_t model_mem [0:scaler_pkg::mem_depth-1];

    scaler_top #(
        .img_dim (img_dim)
    ) dut0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .key_n       (key_n),
        .view_manual (view_manual),
        .run         (run),
        .scale       (scale),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .load_write  (load_write),
        .hex0        (hex0),
        .hex1        (hex1),
        .hex2        (hex2),
        .hex3        (hex3),
        .hex4        (hex4),
        .hex5        (hex5),
        .busy        (busy),
        .ready       (ready)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ======================================================================
    // Reporting and compare tasks
    // ======================================================================
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_seg(input string name, input scaler_pkg::seg_t got,
                             input scaler_pkg::seg_t exp);
        if (got !== exp)
            report_failure($sformatf("error: time %0t signal %s got %b expected %b",
                                     $time, name, got, exp));
    endtask

    task automatic check_pixel(input string name, input scaler_pkg::pixel_t got,
                               input scaler_pkg::pixel_t exp);
        if (got !== exp)
            report_failure($sformatf("error: time %0t signal %s got %h expected %h",
                                     $time, name, got, exp));
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================
    // Active-low segments g..a for one hex digit
    function automatic scaler_pkg::seg_t seg_pattern(input logic [3:0] d);
        case (d)
            4'h0: return 7'b100_0000;
            4'h1: return 7'b111_1001;
            4'h2: return 7'b010_0100;
            4'h3: return 7'b011_0000;
            4'h4: return 7'b001_1001;
            4'h5: return 7'b001_0010;
            4'h6: return 7'b000_0010;
            4'h7: return 7'b111_1000;
            4'h8: return 7'b000_0000;
            4'h9: return 7'b001_0000;
            4'ha: return 7'b000_1000;
            4'hb: return 7'b000_0011;
            4'hc: return 7'b100_0110;
            4'hd: return 7'b010_0001;
            4'he: return 7'b000_0110;
            default: return 7'b000_1110;
        endcase
    endfunction

    // Digit value shown by a pattern, -1 when it is no hex digit
    function automatic int digit_of(input scaler_pkg::seg_t s);
        for (int i = 0; i < 16; i++) begin
            if (seg_pattern(4'(i)) === s)
                return i;
        end
        return -1;
    endfunction

    function automatic int clamp_index(input int v);
        return (v > img_dim - 1) ? img_dim - 1 : v;
    endfunction

    // Bilinear sample for one output coordinate, truncated
    function automatic scaler_pkg::pixel_t expected_pixel(input int ox, input int oy,
                                                          input int inv);
        int sx;
        int sy;
        int xa;
        int xb;
        int ya;
        int yb;
        int top;
        int bot;
        sx  = ox * inv;
        sy  = oy * inv;
        xa  = clamp_index(sx / 256);
        xb  = clamp_index(sx / 256 + 1);
        ya  = clamp_index(sy / 256);
        yb  = clamp_index(sy / 256 + 1);
        top = model_mem[ya * img_dim + xa] * (256 - sx % 256)
            + model_mem[ya * img_dim + xb] * (sx % 256);
        bot = model_mem[yb * img_dim + xa] * (256 - sx % 256)
            + model_mem[yb * img_dim + xb] * (sx % 256);
        return scaler_pkg::pixel_t'((top * (256 - sy % 256) + bot * (sy % 256)) >> 16);
    endfunction

    // ======================================================================
    // Stimulus tasks, all start and end just after a falling edge
    // ======================================================================
    task automatic check_display(input scaler_pkg::addr_t exp_addr,
                                 input scaler_pkg::pixel_t exp_data);
        int hi;
        int lo;
        check_seg("hex2", hex2, seg_pattern(exp_addr[3:0]));
        check_seg("hex3", hex3, seg_pattern(exp_addr[7:4]));
        check_seg("hex4", hex4, seg_pattern(exp_addr[11:8]));
        check_seg("hex5", hex5, seg_pattern(exp_addr[15:12]));
        hi = digit_of(hex1);
        lo = digit_of(hex0);
        if (hi < 0 || lo < 0)
            report_failure("The data digits show a pattern that is no hex digit");
        else
            check_pixel("hex1..hex0", scaler_pkg::pixel_t'({hi[3:0], lo[3:0]}), exp_data);
    endtask

    // Memory read plus display register
    task automatic view_load(input scaler_pkg::addr_t a);
        load_addr = a;
        repeat (2) @(negedge clk);
        check_display(a, model_mem[a]);
    endtask

    task automatic write_byte(input scaler_pkg::addr_t a, input scaler_pkg::pixel_t d);
        load_addr  = a;
        load_data  = d;
        load_write = 1'b1;
        @(negedge clk);
        load_write = 1'b0;
        model_mem[a] = d;
    endtask

    // Long enough for sampling, edge pulse, address step and display
    task automatic press_key(input int idx);
        key_n[idx] = 1'b0;
        repeat (4) @(negedge clk);
        key_n[idx] = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    task automatic wait_flag(input int which, input logic level, input int limit,
                             input bit busy_ok, input string what);
        int n;
        bit busy_seen;
        n         = 0;
        busy_seen = 1'b0;
        while (((which == sel_ready) ? ready : busy) !== level && n < limit) begin
            @(negedge clk);
            busy_seen = busy_seen | busy;
            n++;
        end
        if (((which == sel_ready) ? ready : busy) !== level)
            report_failure({what, " before the timeout"});
        else if (!busy_ok && busy_seen)
            report_failure("The engine went busy although the output image is empty");
    endtask

    // One full run, model update and readback of the output image
    task automatic run_scale(input scaler_pkg::scale_t s);
        int od;
        int inv;
        scaler_pkg::addr_t a;
        od    = (img_dim * int'(s)) >> 8;
        inv   = (s == 0) ? 256 : 65536 / int'(s);
        scale = s;
        run   = 1'b1;
        @(negedge clk);
        if (od != 0)
            wait_flag(sel_busy, 1'b1, short_limit, 1'b1, "busy did not rise after run");
        wait_flag(sel_ready, 1'b1, run_limit, od != 0, "ready did not rise");
        if (busy)
            report_failure("busy stayed high together with ready");
        run = 1'b0;
        wait_flag(sel_ready, 1'b0, short_limit, 1'b0, "ready did not fall after run dropped");
        for (int y = 0; y < od; y++) begin
            for (int x = 0; x < od; x++) begin
                a = scaler_pkg::addr_t'(scaler_pkg::output_base + y * od + x);
                model_mem[a] = expected_pixel(x, y, inv);
                view_load(a);
            end
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        seed        = 32'h2fd35cf9;
        clk         = 1'b0;
        reset_n     = 1'b0;
        key_n       = 3'b111;
        view_manual = 1'b0;
        run         = 1'b0;
        scale       = '0;
        load_addr   = '0;
        load_data   = '0;
        load_write  = 1'b0;
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        if (busy || ready)
            report_failure("busy or ready is high after reset");

        // Random image, then readback in load view
        for (int a = 0; a < img_dim * img_dim; a++)
            write_byte(scaler_pkg::addr_t'(a), scaler_pkg::pixel_t'($random(seed)));
        for (int a = 0; a < img_dim * img_dim; a++)
            view_load(scaler_pkg::addr_t'(a));

        // Manual view, floor at zero both ways
        view_manual = 1'b1;
        repeat (2) @(negedge clk);
        check_display('0, model_mem[0]);
        press_key(1);
        check_display('0, model_mem[0]);
        for (int i = 1; i <= 3; i++) begin
            press_key(0);
            check_display(scaler_pkg::addr_t'(i), model_mem[i]);
        end
        press_key(1);
        check_display(16'd2, model_mem[2]);
        repeat (3) press_key(1);
        check_display('0, model_mem[0]);
        view_manual = 1'b0;

        // Random factor, then the edge cases
        run_scale(scaler_pkg::scale_t'(16 + {$random(seed)} % 240));
        run_scale(8'd255);
        run_scale(8'd129);

        // Abort a long run with the clear key
        scale = 8'd255;
        run   = 1'b1;
        @(negedge clk);
        wait_flag(sel_busy, 1'b1, short_limit, 1'b1, "busy did not rise before the abort");
        repeat (20 + {$random(seed)} % 30) @(negedge clk);
        key_n[2] = 1'b0;
        run      = 1'b0;
        wait_flag(sel_busy, 1'b0, short_limit, 1'b1, "busy did not fall after the clear key");
        if (ready)
            report_failure("ready rose after the clear key");
        key_n[2] = 1'b1;
        repeat (4) @(negedge clk);
        run_scale(scaler_pkg::scale_t'(16 + {$random(seed)} % 240));

        // Zero factor leaves the output region untouched
        for (int i = 0; i < 16; i++)
            write_byte(scaler_pkg::addr_t'(scaler_pkg::output_base + i),
                       scaler_pkg::pixel_t'($random(seed)));
        run_scale(8'd0);
        for (int i = 0; i < 16; i++)
            view_load(scaler_pkg::addr_t'(scaler_pkg::output_base + i));

        $display("** PASS **");
        $finish;
    end

endmodule

//--- scaler.f
common/scaler_pkg.sv
common/fetch_if.sv
hdl/key_input.sv
hdl/pixel_ram.sv
hdl/seg_display.sv
scaler/scan_control.sv
scaler/neighbour_fetch.sv
scaler/bilinear_datapath.sv
hdl/scaler_top.sv
verification/scaler_properties.sv
verification/scaler_tb.sv

//--- Bender.yml
package:
  name: scaler

sources:
  - common/scaler_pkg.sv
  - common/fetch_if.sv
  - hdl/key_input.sv
  - hdl/pixel_ram.sv
  - hdl/seg_display.sv
  - scaler/scan_control.sv
  - scaler/neighbour_fetch.sv
  - scaler/bilinear_datapath.sv
  - hdl/scaler_top.sv
  - target: test
    files:
      - verification/scaler_properties.sv
      - verification/scaler_tb.sv
